// File: hdl/csr_pkg.sv
// shared CSR op codes, addresses, counter indices and reset constants; imported by the CSR modules
package csr_pkg;

  // csr instruction operation, matches the core's 2-bit op field
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // machine group addresses
  localparam logic [11:0] CSR_MSTATUS   = 12'h300;
  localparam logic [11:0] CSR_MEPC      = 12'h341;
  localparam logic [11:0] CSR_MCAUSE    = 12'h342;
  localparam logic [11:0] CSR_MCPUID    = 12'hF00;  // read only
  localparam logic [11:0] CSR_MIMPID    = 12'hF01;  // read only
  localparam logic [11:0] CSR_MHARTID   = 12'hF10;  // read only

  // performance counter group addresses
  localparam logic [11:0] CSR_PCER      = 12'h7A0;
  localparam logic [11:0] CSR_PCMR      = 12'h7A1;
  localparam logic [11:0] CSR_PCCR_ALL  = 12'h79F;  // write hits every counter
  localparam logic [11:0] CSR_PCCR_BASE = 12'h780;  // counter i sits at base + i

  localparam int N_PERF_COUNTERS = 8;

  // event index = counter index = PCER bit
  localparam int EV_CYCLE        = 0;
  localparam int EV_INSTR        = 1;
  localparam int EV_LD_STALL     = 2;
  localparam int EV_JR_STALL     = 3;
  localparam int EV_IMISS        = 4;
  localparam int EV_LOAD         = 5;
  localparam int EV_STORE        = 6;
  localparam int EV_BRANCH_TAKEN = 7;

  localparam logic [31:0] MCPUID_VAL = 32'h0000_0100;  // rv32i
  localparam logic [31:0] MIMPID_VAL = 32'h0000_8000;
  localparam logic [1:0]  PCMR_RESET = 2'b11;          // saturate and global enable

endpackage

// File: hdl/csr_access_ctrl.sv
// CSR access decode between machine and counter groups, read mux and write value; in csr_top
`timescale 1ns/1ps

module csr_access_ctrl
  import csr_pkg::*;
(
  input  logic        csr_access_i,
  input  logic [11:0] csr_addr_i,
  input  csr_op_e     csr_op_i,
  input  logic [31:0] csr_wdata_i,

  input  logic [31:0] mach_rdata_i,  // group read values
  input  logic [31:0] perf_rdata_i,

  output logic [31:0] csr_rdata_o,
  output logic        mach_we_o,
  output logic        perf_we_o,
  output logic [31:0] csr_wval_o
);

  logic        is_perf;    // counter group hit
  logic        write_req;  // any modifying access
  logic [31:0] old_val;    // current register value

  ////////////////////////////////////////////////////////////////////////////
  // group decode, 780h..79Fh plus PCER/PCMR

  assign is_perf = (csr_addr_i == CSR_PCER) ||
                   (csr_addr_i == CSR_PCMR) ||
                   (csr_addr_i[11:5] == CSR_PCCR_BASE[11:5]);

  assign old_val     = is_perf ? perf_rdata_i : mach_rdata_i;
  assign csr_rdata_o = csr_access_i ? old_val : 32'b0;  // idle bus reads zero

  assign write_req = csr_access_i && (csr_op_i != CSR_OP_NONE);
  assign mach_we_o = write_req && !is_perf;
  assign perf_we_o = write_req && is_perf;

  // read-modify-write value
  always_comb
  begin
    unique case (csr_op_i)
      CSR_OP_WRITE: csr_wval_o = csr_wdata_i;
      CSR_OP_SET:   csr_wval_o = old_val | csr_wdata_i;
      CSR_OP_CLEAR: csr_wval_o = old_val & ~csr_wdata_i;
      default:      csr_wval_o = csr_wdata_i;  // no strobe anyway
    endcase
  end

  // a write needs a clean address, else both groups could take it
  always_comb
  begin
    a_one_strobe: assert (!write_req ||
                          (!$isunknown(csr_addr_i) && $onehot0({mach_we_o, perf_we_o})))
      else $error("CSR write with unknown address or both group strobes active");
  end

endmodule

// File: hdl/csr_machine_regs.sv
// machine CSRs (mstatus, mepc, mcause, ID regs) with exception capture; instanced by csr_top
`timescale 1ns/1ps

module csr_machine_regs
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  input  logic [11:0] csr_addr_i,
  input  logic        mach_we_i,     // group strobe from access ctrl
  input  logic [31:0] csr_wval_i,    // final write value after set/clear

  input  logic        save_pc_i,     // exception controller capture
  input  logic [31:0] curr_pc_i,
  input  logic        save_cause_i,
  input  logic [5:0]  exc_cause_i,   // bit 5 is the interrupt flag

  input  logic [4:0]  core_id_i,
  input  logic [4:0]  cluster_id_i,

  output logic [31:0] mach_rdata_o,
  output logic        irq_enable_o,
  output logic [31:0] epc_o
);

  logic        irq_enable_q;  // mstatus.ie
  logic [31:0] mepc_q;
  logic [5:0]  mcause_q;      // {irq flag, code}

  ////////////////////////////////////////////////////////////////////////////
  // read side, architectural layout

  always_comb
  begin
    mach_rdata_o = '0;  // unmapped reads zero
    unique case (csr_addr_i)
      CSR_MSTATUS: mach_rdata_o = {29'b0, 2'b11, irq_enable_q};  // always machine mode
      CSR_MEPC:    mach_rdata_o = mepc_q;
      CSR_MCAUSE:  mach_rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      CSR_MCPUID:  mach_rdata_o = MCPUID_VAL;
      CSR_MIMPID:  mach_rdata_o = MIMPID_VAL;
      CSR_MHARTID: mach_rdata_o = {22'b0, cluster_id_i, core_id_i};
      default:     mach_rdata_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // storage, exception capture beats a csr write

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      irq_enable_q <= 1'b0;
      mepc_q       <= '0;
      mcause_q     <= '0;
    end
    else
    begin
      if (mach_we_i && csr_addr_i == CSR_MSTATUS)
        irq_enable_q <= csr_wval_i[0];

      if (save_pc_i)
        mepc_q <= curr_pc_i;
      else if (mach_we_i && csr_addr_i == CSR_MEPC)
        mepc_q <= csr_wval_i;

      if (save_cause_i)
        mcause_q <= exc_cause_i;
      else if (mach_we_i && csr_addr_i == CSR_MCAUSE)
        mcause_q <= {csr_wval_i[31], csr_wval_i[4:0]};  // flag moves back to bit 5
    end
  end

  assign irq_enable_o = irq_enable_q;
  assign epc_o        = mepc_q;

  // capture control must be clean, an X here corrupts mepc silently
  a_save_pc_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(save_pc_i))
    else $error("save_pc_i unknown after reset");

endmodule

// File: hdl/csr_perf_counters.sv
// performance counter unit (PCCR, PCER, PCMR) with event qualification; instanced by csr_top
`timescale 1ns/1ps

module csr_perf_counters
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  input  logic [11:0] csr_addr_i,
  input  logic        perf_we_i,       // group strobe from access ctrl
  input  logic [31:0] csr_wval_i,

  // core events
  input  logic        id_valid_i,      // id stage done
  input  logic        is_decoding_i,   // controller in decode
  input  logic        ld_stall_i,      // load use hazard
  input  logic        jr_stall_i,      // jump register hazard
  input  logic        imiss_i,         // waiting on fetch
  input  logic        pc_set_i,        // pc redirected
  input  logic        mem_load_i,
  input  logic        mem_store_i,
  input  logic        branch_i,
  input  logic        branch_taken_i,

  output logic [31:0] perf_rdata_o
);

  logic                              id_valid_q;
  logic [N_PERF_COUNTERS-1:0]        ev;          // qualified events
  logic [N_PERF_COUNTERS-1:0]        inc;         // enabled events, this cycle
  logic [N_PERF_COUNTERS-1:0]        inc_q;       // applied one edge later
  logic [N_PERF_COUNTERS-1:0]        pcer_q;      // per counter enable
  logic [1:0]                        pcmr_q;      // [1] saturate, [0] global enable
  logic [N_PERF_COUNTERS-1:0][31:0] pccr_q;
  logic [N_PERF_COUNTERS-1:0][31:0] pccr_n;

  ////////////////////////////////////////////////////////////////////////////
  // event qualification

  assign ev[EV_CYCLE]        = 1'b1;
  assign ev[EV_INSTR]        = id_valid_i & is_decoding_i;
  assign ev[EV_LD_STALL]     = ld_stall_i & id_valid_q;
  assign ev[EV_JR_STALL]     = jr_stall_i & id_valid_q;
  assign ev[EV_IMISS]        = imiss_i & ~pc_set_i;  // branch refetch not counted
  assign ev[EV_LOAD]         = mem_load_i;
  assign ev[EV_STORE]        = mem_store_i;
  assign ev[EV_BRANCH_TAKEN] = branch_i & branch_taken_i & id_valid_q;

  assign inc = ev & pcer_q & {N_PERF_COUNTERS{pcmr_q[0]}};

  // read mux, only own registers
  always_comb
  begin
    perf_rdata_o = '0;  // 79Fh and empty slots read zero
    if (csr_addr_i == CSR_PCER)
      perf_rdata_o[N_PERF_COUNTERS-1:0] = pcer_q;
    if (csr_addr_i == CSR_PCMR)
      perf_rdata_o[1:0] = pcmr_q;
    for (int i = 0; i < N_PERF_COUNTERS; i++)
    begin
      if (csr_addr_i == CSR_PCCR_BASE + 12'(i))
        perf_rdata_o = pccr_q[i];
    end
  end

  // counter next value, write wins over increment
  always_comb
  begin
    for (int i = 0; i < N_PERF_COUNTERS; i++)
    begin
      pccr_n[i] = pccr_q[i];
      if (inc_q[i] && (pccr_q[i] != '1 || !pcmr_q[1]))
        pccr_n[i] = pccr_q[i] + 32'd1;  // wraps when saturate off
      if (perf_we_i && (csr_addr_i == CSR_PCCR_ALL || csr_addr_i == CSR_PCCR_BASE + 12'(i)))
        pccr_n[i] = csr_wval_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= PCMR_RESET;
      pccr_q     <= '0;
    end
    else
    begin
      id_valid_q <= id_valid_i;
      inc_q      <= inc;
      pccr_q     <= pccr_n;
      if (perf_we_i && csr_addr_i == CSR_PCER)
        pcer_q <= csr_wval_i[N_PERF_COUNTERS-1:0];
      if (perf_we_i && csr_addr_i == CSR_PCMR)
        pcmr_q <= csr_wval_i[1:0];
    end
  end

  // enable clear this cycle means no pending increment next cycle
  a_frozen_when_disabled: assert property (@(posedge clk) disable iff (!rst_n)
    !pcmr_q[0] ##1 !perf_we_i |=> $stable(pccr_q))
    else $error("counter moved with PCMR enable clear");

endmodule

// File: hdl/csr_top.sv
// CSR block top level, connects access control, machine registers and counters to the core
`timescale 1ns/1ps

module csr_top
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // single cycle csr access
  input  logic        csr_access_i,
  input  logic [11:0] csr_addr_i,
  input  csr_op_e     csr_op_i,
  input  logic [31:0] csr_wdata_i,
  output logic [31:0] csr_rdata_o,

  input  logic [4:0]  core_id_i,
  input  logic [4:0]  cluster_id_i,

  // exception controller
  input  logic        save_pc_i,
  input  logic [31:0] curr_pc_i,
  input  logic        save_cause_i,
  input  logic [5:0]  exc_cause_i,

  output logic        irq_enable_o,
  output logic [31:0] epc_o,

  // counter events
  input  logic        id_valid_i,
  input  logic        is_decoding_i,
  input  logic        ld_stall_i,
  input  logic        jr_stall_i,
  input  logic        imiss_i,
  input  logic        pc_set_i,
  input  logic        mem_load_i,
  input  logic        mem_store_i,
  input  logic        branch_i,
  input  logic        branch_taken_i
);

  logic        mach_we;
  logic        perf_we;
  logic [31:0] csr_wval;
  logic [31:0] mach_rdata;
  logic [31:0] perf_rdata;

  csr_access_ctrl u_access_ctrl (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .mach_rdata_i (mach_rdata),
    .perf_rdata_i (perf_rdata),
    .csr_rdata_o  (csr_rdata_o),
    .mach_we_o    (mach_we),
    .perf_we_o    (perf_we),
    .csr_wval_o   (csr_wval)
  );

  csr_machine_regs u_machine_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_addr_i   (csr_addr_i),
    .mach_we_i    (mach_we),
    .csr_wval_i   (csr_wval),
    .save_pc_i    (save_pc_i),
    .curr_pc_i    (curr_pc_i),
    .save_cause_i (save_cause_i),
    .exc_cause_i  (exc_cause_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .mach_rdata_o (mach_rdata),
    .irq_enable_o (irq_enable_o),
    .epc_o        (epc_o)
  );

  csr_perf_counters u_perf_counters (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_addr_i     (csr_addr_i),
    .perf_we_i      (perf_we),
    .csr_wval_i     (csr_wval),
    .id_valid_i     (id_valid_i),
    .is_decoding_i  (is_decoding_i),
    .ld_stall_i     (ld_stall_i),
    .jr_stall_i     (jr_stall_i),
    .imiss_i        (imiss_i),
    .pc_set_i       (pc_set_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i),
    .branch_i       (branch_i),
    .branch_taken_i (branch_taken_i),
    .perf_rdata_o   (perf_rdata)
  );

endmodule

// File: sim/csr_checker.sv
// testbench checker, compares the CSR block outputs with each data line's expected values
`timescale 1ns/1ps

module csr_checker (
  input  logic        clk,
  input  logic        check_en_i,    // a data line is on the DUT inputs
  input  logic        run_done_i,    // last line has been applied
  input  int          test_id_i,
  input  int          line_no_i,
  input  logic [31:0] exp_rdata_i,
  input  logic        exp_irq_i,
  input  logic [31:0] exp_epc_i,
  input  logic [31:0] csr_rdata_i,   // DUT outputs
  input  logic        irq_enable_i,
  input  logic [31:0] epc_i,
  output int          n_tests_o,
  output int          n_failed_o,
  output int          n_checks_o,
  output int          n_errors_o
);

  int cur_test    = 0;  // 0 until the first line arrives
  int test_checks = 0;
  int test_errors = 0;
  int tests       = 0;
  int failed      = 0;
  int checks      = 0;
  int errors      = 0;

  assign n_tests_o  = tests;
  assign n_failed_o = failed;
  assign n_checks_o = checks;
  assign n_errors_o = errors;

  initial
  begin
    $timeformat(-9, 0, " ns", 0);
  end

  // one field of one line
  task automatic compare_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    test_checks++;
    if (actual !== expected)
    begin
      errors++;
      test_errors++;
      $display("FAIL %t: test %0d line %0d, %s expected %h got %h",
               $realtime, test_id_i, line_no_i, name, expected, actual);
    end
  endtask

  // result line for the test that just ended
  task automatic close_test();
    tests++;
    if (test_errors != 0)
      failed++;
    $display("test %0d %s: %0d checks, %0d errors", cur_test,
             (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sample mid cycle, inputs and outputs settled since the rising edge

  always @(negedge clk)
  begin
    if (check_en_i)
    begin
      if (test_id_i != cur_test)
      begin
        if (cur_test != 0)
          close_test();  // new tag ends the previous test
        cur_test = test_id_i;
      end
      compare_field("rdata", exp_rdata_i, csr_rdata_i);  // combinational read
      compare_field("irq_enable", {31'b0, exp_irq_i}, {31'b0, irq_enable_i});
      compare_field("epc", exp_epc_i, epc_i);
    end
    else if (run_done_i && cur_test != 0)
    begin
      close_test();
      cur_test = 0;
    end
  end

endmodule

// File: sim/tb_csr_top.sv
// testbench top for the CSR block, replays sim/csr_testdata.txt one line per clock cycle
`timescale 1ns/1ps

module tb_csr_top
  import csr_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int N_COLS     = 13;  // words per data line
  localparam int MAX_LINES  = 64;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        csr_access;
  logic [11:0] csr_addr;
  csr_op_e     csr_op;
  logic [31:0] csr_wdata;
  logic [31:0] csr_rdata;
  logic [4:0]  core_id;
  logic [4:0]  cluster_id;
  logic        save_pc;
  logic [31:0] curr_pc;
  logic        save_cause;
  logic [5:0]  exc_cause;
  logic        irq_enable;
  logic [31:0] epc;
  logic [9:0]  events;  // id_valid in bit 0 up to branch_taken in bit 9

  logic [31:0] td [0:N_COLS*MAX_LINES-1];  // flat data file image
  int          n_lines = 0;
  logic        check_en;
  logic        run_done;
  int          test_id;
  int          line_no;
  logic [31:0] exp_rdata;
  logic        exp_irq;
  logic [31:0] exp_epc;
  int          n_tests;
  int          n_failed;
  int          n_checks;
  int          n_errors;

  always #(CLK_PERIOD / 2) clk = ~clk;

  // one data line onto the DUT inputs and the checker
  task automatic apply_line(input int l);
    int b;
    b = l * N_COLS;
    test_id    <= int'(td[b]);
    csr_access <= td[b+1][0];
    csr_op     <= csr_op_e'(td[b+2][1:0]);
    csr_addr   <= td[b+3][11:0];
    csr_wdata  <= td[b+4];
    save_pc    <= td[b+5][0];
    save_cause <= td[b+6][0];
    curr_pc    <= td[b+7];
    exc_cause  <= td[b+8][5:0];
    events     <= td[b+9][9:0];
    exp_rdata  <= td[b+10];
    exp_irq    <= td[b+11][0];
    exp_epc    <= td[b+12];
    line_no    <= l + 1;
    check_en   <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and final report

  initial
  begin : stimulus
    rst_n      <= 1'b0;
    csr_access <= 1'b0;
    csr_op     <= CSR_OP_NONE;
    csr_addr   <= '0;
    csr_wdata  <= '0;
    core_id    <= 5'd3;  // mhartid reads 23h
    cluster_id <= 5'd1;
    save_pc    <= 1'b0;
    curr_pc    <= '0;
    save_cause <= 1'b0;
    exc_cause  <= '0;
    events     <= '0;
    check_en   <= 1'b0;
    run_done   <= 1'b0;
    test_id    <= 0;
    line_no    <= 0;
    exp_rdata  <= '0;
    exp_irq    <= 1'b0;
    exp_epc    <= '0;
    for (int i = 0; i < N_COLS * MAX_LINES; i++)
      td[i] = '1;  // all ones tag marks the end of the file
    $readmemh("sim/csr_testdata.txt", td);
    while (n_lines < MAX_LINES && td[n_lines * N_COLS] != '1)
      n_lines++;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    for (int l = 0; l < n_lines; l++)
    begin
      @(posedge clk);
      apply_line(l);
    end
    @(posedge clk);
    check_en   <= 1'b0;
    run_done   <= 1'b1;
    csr_access <= 1'b0;
    events     <= '0;
    repeat (2) @(posedge clk);  // checker closes the last test on the way
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0 && n_failed == 0 && n_checks > 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // watchdog, the run needs reset plus one cycle per line
  initial
  begin : watchdog
    wait (n_lines > 0);
    #((n_lines + 40) * CLK_PERIOD);
    $display("timeout: run still going after %0d clock periods", n_lines + 40);
    $display(">>> FAIL");
    $finish;
  end

  csr_top csr_top_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_access_i   (csr_access),
    .csr_addr_i     (csr_addr),
    .csr_op_i       (csr_op),
    .csr_wdata_i    (csr_wdata),
    .csr_rdata_o    (csr_rdata),
    .core_id_i      (core_id),
    .cluster_id_i   (cluster_id),
    .save_pc_i      (save_pc),
    .curr_pc_i      (curr_pc),
    .save_cause_i   (save_cause),
    .exc_cause_i    (exc_cause),
    .irq_enable_o   (irq_enable),
    .epc_o          (epc),
    .id_valid_i     (events[0]),
    .is_decoding_i  (events[1]),
    .ld_stall_i     (events[2]),
    .jr_stall_i     (events[3]),
    .imiss_i        (events[4]),
    .pc_set_i       (events[5]),
    .mem_load_i     (events[6]),
    .mem_store_i    (events[7]),
    .branch_i       (events[8]),
    .branch_taken_i (events[9])
  );

  csr_checker csr_checker_i (
    .clk          (clk),
    .check_en_i   (check_en),
    .run_done_i   (run_done),
    .test_id_i    (test_id),
    .line_no_i    (line_no),
    .exp_rdata_i  (exp_rdata),
    .exp_irq_i    (exp_irq),
    .exp_epc_i    (exp_epc),
    .csr_rdata_i  (csr_rdata),
    .irq_enable_i (irq_enable),
    .epc_i        (epc),
    .n_tests_o    (n_tests),
    .n_failed_o   (n_failed),
    .n_checks_o   (n_checks),
    .n_errors_o   (n_errors)
  );

endmodule

// File: project.f
hdl/csr_pkg.sv
hdl/csr_access_ctrl.sv
hdl/csr_machine_regs.sv
hdl/csr_perf_counters.sv
hdl/csr_top.sv
sim/csr_checker.sv
sim/tb_csr_top.sv

// File: run_sim.sh
#!/bin/sh
# build the CSR testbench with Verilator, run it from the project root, judge the log
verilator --binary --timing --assert -f project.f --top-module tb_csr_top -o tb_csr_top \
  && ./obj_dir/tb_csr_top > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qF ">>> FAIL" sim.log && { echo "simulation reported failure"; exit 1; } \
  || echo "simulation reported no failure"

// File: sim/csr_testdata.txt
// test acc op addr wdata save_pc save_cause pc cause events | exp_rdata exp_irq exp_epc
// op 0 none 1 write 2 set 3 clear; events bit 0 id_valid .. bit 6 load, 7 store, 9 br_taken
1 1 0 300 00000000 0 0 00000000 00 000 00000006 0 00000000
1 1 0 7a0 00000000 0 0 00000000 00 000 00000000 0 00000000
1 1 0 7a1 00000000 0 0 00000000 00 000 00000003 0 00000000
1 1 0 f00 00000000 0 0 00000000 00 000 00000100 0 00000000
1 1 0 f01 00000000 0 0 00000000 00 000 00008000 0 00000000
1 1 0 f10 00000000 0 0 00000000 00 000 00000023 0 00000000
1 1 0 123 00000000 0 0 00000000 00 000 00000000 0 00000000
2 1 1 300 00000001 0 0 00000000 00 000 00000006 0 00000000
2 1 2 341 00001000 0 0 00000000 00 000 00000000 1 00000000
2 1 3 300 00000001 0 0 00000000 00 000 00000007 1 00001000
2 1 1 342 8000001f 0 0 00000000 00 000 00000000 0 00001000
2 1 3 342 0000000f 0 0 00000000 00 000 8000001f 0 00001000
2 0 1 341 00000005 0 0 00000000 00 000 00000000 0 00001000
2 1 0 342 ffffffff 0 0 00000000 00 000 80000010 0 00001000
3 1 1 341 00002222 1 0 0000abc0 00 000 00001000 0 00001000
3 1 1 342 00000003 0 1 00000000 25 000 80000010 0 0000abc0
3 1 0 342 00000000 0 0 00000000 00 000 80000005 0 0000abc0
4 1 1 7a0 00000060 0 0 00000000 00 000 00000000 0 0000abc0
4 0 0 000 00000000 0 0 00000000 00 0c0 00000000 0 0000abc0
4 0 0 000 00000000 0 0 00000000 00 0c0 00000000 0 0000abc0
4 0 0 000 00000000 0 0 00000000 00 040 00000000 0 0000abc0
4 1 0 780 00000000 0 0 00000000 00 000 00000000 0 0000abc0
4 1 0 785 00000000 0 0 00000000 00 000 00000003 0 0000abc0
4 1 0 786 00000000 0 0 00000000 00 000 00000002 0 0000abc0
5 1 1 785 fffffffe 0 0 00000000 00 000 00000003 0 0000abc0
5 0 0 000 00000000 0 0 00000000 00 040 00000000 0 0000abc0
5 0 0 000 00000000 0 0 00000000 00 040 00000000 0 0000abc0
5 0 0 000 00000000 0 0 00000000 00 040 00000000 0 0000abc0
5 1 0 785 00000000 0 0 00000000 00 000 ffffffff 0 0000abc0
5 1 1 7a1 00000001 0 0 00000000 00 000 00000003 0 0000abc0
5 1 1 785 fffffffe 0 0 00000000 00 000 ffffffff 0 0000abc0
5 0 0 000 00000000 0 0 00000000 00 040 00000000 0 0000abc0
5 0 0 000 00000000 0 0 00000000 00 040 00000000 0 0000abc0
5 0 0 000 00000000 0 0 00000000 00 040 00000000 0 0000abc0
5 0 0 000 00000000 0 0 00000000 00 000 00000000 0 0000abc0
5 1 0 785 00000000 0 0 00000000 00 000 00000001 0 0000abc0
6 1 1 79f 00000100 0 0 00000000 00 000 00000000 0 0000abc0
6 1 1 7a1 00000000 0 0 00000000 00 000 00000001 0 0000abc0
6 0 0 000 00000000 0 0 00000000 00 0c0 00000000 0 0000abc0
6 0 0 000 00000000 0 0 00000000 00 0c0 00000000 0 0000abc0
6 1 0 785 00000000 0 0 00000000 00 0c0 00000100 0 0000abc0
6 1 0 786 00000000 0 0 00000000 00 0c0 00000100 0 0000abc0
6 1 0 782 00000000 0 0 00000000 00 0c0 00000100 0 0000abc0
